/* design/ntm_scalar_pkg.sv */
// Scalar arithmetic peripheral shared definitions
// Operand widths, memory and APB address types, the ALU opcode
// and the host-visible register map
package ntm_scalar_pkg;

  //////////////////////////////
  // Widths
  localparam int DATA_WIDTH     = 32;
  localparam int MEM_DEPTH      = 16;
  localparam int MEM_ADDR_WIDTH = $clog2(MEM_DEPTH);
  localparam int APB_ADDR_WIDTH = 8;

  //////////////////////////////
  // Types
  typedef logic [DATA_WIDTH-1:0]     data_t;
  // One extra bit for the adder carry
  typedef logic [DATA_WIDTH:0]       wide_t;
  typedef logic [MEM_ADDR_WIDTH-1:0] mem_addr_t;
  typedef logic [APB_ADDR_WIDTH-1:0] apb_addr_t;

  typedef enum logic {OP_ADD = 1'b0, OP_SUB = 1'b1} ntm_op_t;

  //////////////////////////////
  // Register map, byte offsets
  localparam apb_addr_t REG_CTRL        = 8'h00;
  localparam apb_addr_t REG_STATUS      = 8'h04;
  localparam apb_addr_t REG_MODULUS     = 8'h08;
  localparam apb_addr_t REG_OPADDR      = 8'h0C;
  localparam apb_addr_t MEM_WINDOW_BASE = 8'h40;

  // Field positions
  localparam int CTRL_START_BIT  = 0;
  localparam int CTRL_OP_BIT     = 1;
  localparam int STATUS_BUSY_BIT = 0;
  localparam int STATUS_DONE_BIT = 1;

endpackage

/* design/ntm_mem_if.sv */
// Operand memory request channel
// One requester talks to the arbitrated memory; req and its fields
// stay stable until gnt, read data follows one cycle after gnt
interface ntm_mem_if
  import ntm_scalar_pkg::*;
();

  // Request side
  logic      req;
  logic      we;
  mem_addr_t addr;
  data_t     wdata;

  // Response side
  logic      gnt;
  data_t     rdata;

  // APB slave or sequencer
  modport requester (
    output req, we, addr, wdata,
    input  gnt, rdata
  );

  // Arbiter and storage
  modport memory (
    input  req, we, addr, wdata,
    output gnt, rdata
  );

endinterface

/* design/ntm_scalar_modular_adder.sv */
// Modular integer adder with START/READY handshake
// Computes (a + b) mod m or (a - b) mod m with a non-negative result,
// reducing by one subtraction of m per cycle; m == 0 gives plain
// 32-bit wrap-around
module ntm_scalar_modular_adder
  import ntm_scalar_pkg::*;
(
  input  logic    CLK,
  input  logic    RST,
  input  logic    start,
  input  ntm_op_t op,
  input  data_t   a,
  input  data_t   b,
  input  data_t   modulus,
  output logic    ready,
  output data_t   result
);

  typedef enum logic {IDLE, REDUCE} add_state_t;

  add_state_t state;
  wide_t      acc;
  data_t      mod_q;
  logic       neg;
  logic       reduce_more;
  data_t      wrapped;
  data_t      reduced;

  // Keep subtracting while acc >= m
  assign reduce_more = (mod_q != '0) && (acc >= {1'b0, mod_q});

  // m == 0, two's-complement result
  assign wrapped = neg ? ('0 - acc[DATA_WIDTH-1:0]) : acc[DATA_WIDTH-1:0];
  // Negative difference folds back as m - |a - b|
  assign reduced = (neg && (acc != '0)) ? (mod_q - acc[DATA_WIDTH-1:0])
                                        : acc[DATA_WIDTH-1:0];

  //////////////////////////////
  // FSM
  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      state <= IDLE;
      ready <= 1'b0;
    end else begin
      ready <= 1'b0;
      case (state)
        IDLE: begin
          if (start) begin
            state <= REDUCE;
          end
        end
        REDUCE: begin
          if (!reduce_more) begin
            ready <= 1'b1;
            state <= IDLE;
          end
        end
        default: state <= IDLE;
      endcase
    end
  end

  // Datapath
  always_ff @(posedge CLK) begin
    if (state == IDLE && start) begin
      mod_q <= modulus;
      if (op == OP_ADD) begin
        acc <= {1'b0, a} + {1'b0, b};
        neg <= 1'b0;
      end else if (a >= b) begin
        acc <= {1'b0, a} - {1'b0, b};
        neg <= 1'b0;
      end else begin
        // Remember the sign, keep magnitude
        acc <= {1'b0, b} - {1'b0, a};
        neg <= 1'b1;
      end
    end else if (state == REDUCE) begin
      if (reduce_more) begin
        acc <= acc - {1'b0, mod_q};
      end else begin
        result <= (mod_q == '0) ? wrapped : reduced;
      end
    end
  end

endmodule

/* design/ntm_adder_sequencer.sv */
// Compute sequencer for the modular adder
// Reads operands A and B from the operand memory, runs the adder and
// writes the result back; busy while running, done pulses at the end
module ntm_adder_sequencer
  import ntm_scalar_pkg::*;
(
  input  logic      CLK,
  input  logic      RST,
  input  logic      start,
  input  ntm_op_t   op,
  input  data_t     modulus,
  input  mem_addr_t a_idx,
  input  mem_addr_t b_idx,
  input  mem_addr_t r_idx,
  output logic      busy,
  output logic      done,
  ntm_mem_if.requester mem
);

  typedef enum logic [2:0] {IDLE, READ_A, READ_B, COMPUTE, WRITE_R} seq_state_t;

  seq_state_t state;
  ntm_op_t    op_q;
  data_t      mod_q;
  mem_addr_t  a_q;
  mem_addr_t  b_q;
  mem_addr_t  r_q;
  data_t      opnd_a;
  data_t      opnd_b;
  data_t      res_q;
  logic       rd_pend;
  logic       add_start;
  logic       add_ready;
  data_t      add_result;

  assign busy = (state != IDLE);

  //////////////////////////////
  // FSM
  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      state     <= IDLE;
      rd_pend   <= 1'b0;
      add_start <= 1'b0;
      done      <= 1'b0;
    end else begin
      // Read data lands next cycle
      rd_pend   <= mem.req && mem.gnt && !mem.we;
      add_start <= 1'b0;
      done      <= 1'b0;
      case (state)
        // Start while busy never reaches here
        IDLE:    if (start) state <= READ_A;
        READ_A:  if (mem.gnt) state <= READ_B;
        READ_B:  if (mem.gnt) state <= COMPUTE;
        COMPUTE: begin
          // Launch once B is captured
          if (rd_pend) add_start <= 1'b1;
          if (add_ready) state <= WRITE_R;
        end
        WRITE_R: begin
          if (mem.gnt) begin
            state <= IDLE;
            done  <= 1'b1;
          end
        end
        default: state <= IDLE;
      endcase
    end
  end

  // Job parameters and operands
  always_ff @(posedge CLK) begin
    if (state == IDLE && start) begin
      op_q  <= op;
      mod_q <= modulus;
      a_q   <= a_idx;
      b_q   <= b_idx;
      r_q   <= r_idx;
    end
    if (rd_pend && state == READ_B) opnd_a <= mem.rdata;
    if (rd_pend && state == COMPUTE) opnd_b <= mem.rdata;
    if (add_ready) res_q <= add_result;
  end

  // Memory requests per state
  always_comb begin
    mem.req   = 1'b0;
    mem.we    = 1'b0;
    mem.addr  = a_q;
    mem.wdata = res_q;
    case (state)
      READ_A:  mem.req = 1'b1;
      READ_B: begin
        mem.req  = 1'b1;
        mem.addr = b_q;
      end
      WRITE_R: begin
        mem.req  = 1'b1;
        mem.we   = 1'b1;
        mem.addr = r_q;
      end
      default: ;
    endcase
  end

  ntm_scalar_modular_adder adder_inst (
    .CLK     (CLK),
    .RST     (RST),
    .start   (add_start),
    .op      (op_q),
    .a       (opnd_a),
    .b       (opnd_b),
    .modulus (mod_q),
    .ready   (add_ready),
    .result  (add_result)
  );

endmodule

/* design/ntm_arbitrated_memory.sv */
// Arbitrated 16-word operand memory
// Two requesters, APB slave and sequencer; a lone request is granted
// in the same cycle, contested requests alternate round-robin
// Writes land on the grant edge, read data is registered per port
module ntm_arbitrated_memory
  import ntm_scalar_pkg::*;
(
  input  logic CLK,
  input  logic RST,
  ntm_mem_if.memory apb_mem,
  ntm_mem_if.memory seq_mem
);

  logic      req_apb;
  logic      req_seq;
  logic      gnt_apb;
  logic      gnt_seq;
  logic      contested;
  // High gives the sequencer the next contested grant
  logic      prio_seq;
  logic      wr_en;
  mem_addr_t sel_addr;
  data_t     sel_wdata;
  data_t     mem_q [MEM_DEPTH];

  //////////////////////////////
  // Arbiter
  assign req_apb   = apb_mem.req;
  assign req_seq   = seq_mem.req;
  assign contested = req_apb && req_seq;

  assign gnt_apb = req_apb && (!req_seq || !prio_seq);
  assign gnt_seq = req_seq && (!req_apb || prio_seq);

  assign apb_mem.gnt = gnt_apb;
  assign seq_mem.gnt = gnt_seq;

  // Loser of a contest wins the next one
  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      prio_seq <= 1'b0;
    end else if (contested) begin
      prio_seq <= !prio_seq;
    end
  end

  //////////////////////////////
  // Storage
  // Mux the granted write port
  assign sel_addr  = gnt_seq ? seq_mem.addr : apb_mem.addr;
  assign sel_wdata = gnt_seq ? seq_mem.wdata : apb_mem.wdata;
  assign wr_en     = (gnt_apb && apb_mem.we) || (gnt_seq && seq_mem.we);

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      foreach (mem_q[i]) begin
        mem_q[i] <= '0;
      end
    end else if (wr_en) begin
      mem_q[sel_addr] <= sel_wdata;
    end
  end

  // Read data per requester, valid the cycle after its grant
  always_ff @(posedge CLK) begin
    if (gnt_apb && !apb_mem.we) begin
      apb_mem.rdata <= mem_q[apb_mem.addr];
    end
    if (gnt_seq && !seq_mem.we) begin
      seq_mem.rdata <= mem_q[seq_mem.addr];
    end
  end

endmodule

/* design/ntm_apb_slave.sv */
// APB slave of the scalar arithmetic peripheral
// Holds CTRL, STATUS, MODULUS and OPADDR with zero wait states
// and maps the 16 operand words at the window base; window
// accesses wait on the memory arbiter through PREADY
module ntm_apb_slave
  import ntm_scalar_pkg::*;
(
  input  logic      CLK,
  input  logic      RST,
  input  logic      PSEL,
  input  logic      PENABLE,
  input  logic      PWRITE,
  input  apb_addr_t PADDR,
  input  data_t     PWDATA,
  output data_t     PRDATA,
  output logic      PREADY,
  output logic      start,
  output ntm_op_t   op,
  output data_t     modulus,
  output mem_addr_t a_idx,
  output mem_addr_t b_idx,
  output mem_addr_t r_idx,
  input  logic      busy,
  input  logic      done,
  ntm_mem_if.requester mem
);

  logic  access;
  logic  win_hit;
  logic  reg_wr;
  logic  start_wr;
  logic  rd_wait;
  logic  done_q;
  data_t reg_rdata;

  // Access phase and window decode
  assign access   = PSEL && PENABLE;
  assign win_hit  = PADDR[7:6] == MEM_WINDOW_BASE[7:6];
  assign reg_wr   = access && PWRITE && !win_hit;
  // Write-one START
  assign start_wr = reg_wr && (PADDR == REG_CTRL) && PWDATA[CTRL_START_BIT];

  //////////////////////////////
  // Control registers
  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      start   <= 1'b0;
      op      <= OP_ADD;
      modulus <= '0;
      a_idx   <= '0;
      b_idx   <= '0;
      r_idx   <= '0;
      done_q  <= 1'b0;
    end else begin
      // One-cycle pulse toward the sequencer
      start <= start_wr;
      if (reg_wr) begin
        case (PADDR)
          REG_CTRL:    op      <= ntm_op_t'(PWDATA[CTRL_OP_BIT]);
          REG_MODULUS: modulus <= PWDATA;
          REG_OPADDR: begin
            a_idx <= PWDATA[3:0];
            b_idx <= PWDATA[7:4];
            r_idx <= PWDATA[11:8];
          end
          default: ;
        endcase
      end
      // Sticky DONE, cleared by a new START
      if (start_wr) begin
        done_q <= 1'b0;
      end else if (done) begin
        done_q <= 1'b1;
      end
    end
  end

  // Register readback
  always_comb begin
    reg_rdata = '0;
    case (PADDR)
      REG_CTRL:    reg_rdata[CTRL_OP_BIT] = op;
      REG_STATUS: begin
        reg_rdata[STATUS_BUSY_BIT] = busy;
        reg_rdata[STATUS_DONE_BIT] = done_q;
      end
      REG_MODULUS: reg_rdata = modulus;
      REG_OPADDR:  reg_rdata[11:0] = {r_idx, b_idx, a_idx};
      default: ;
    endcase
  end

  //////////////////////////////
  // Memory window path
  // Request drops once a read is granted and data is pending
  assign mem.req   = access && win_hit && !rd_wait;
  assign mem.we    = PWRITE;
  assign mem.addr  = PADDR[MEM_ADDR_WIDTH+1:2];
  assign mem.wdata = PWDATA;

  // Read data arrives the cycle after the grant
  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      rd_wait <= 1'b0;
    end else begin
      rd_wait <= mem.req && mem.gnt && !PWRITE;
    end
  end

  // Writes finish on the grant, reads one cycle later
  assign PREADY = win_hit ? (PWRITE ? mem.gnt : rd_wait) : 1'b1;
  assign PRDATA = win_hit ? mem.rdata : reg_rdata;

endmodule

/* design/ntm_scalar_top.sv */
// Scalar arithmetic peripheral top level
// APB slave, adder sequencer and the arbitrated operand memory,
// joined by two memory request channels; no error responses
module ntm_scalar_top
  import ntm_scalar_pkg::*;
(
  input  logic      CLK,
  input  logic      RST,
  input  logic      PSEL,
  input  logic      PENABLE,
  input  logic      PWRITE,
  input  apb_addr_t PADDR,
  input  data_t     PWDATA,
  output data_t     PRDATA,
  output logic      PREADY,
  output logic      PSLVERR
);

  // Memory channels, one per requester
  ntm_mem_if apb_mem ();
  ntm_mem_if seq_mem ();

  // Job control between APB slave and sequencer
  logic      start;
  logic      busy;
  logic      done;
  ntm_op_t   op;
  data_t     modulus;
  mem_addr_t a_idx;
  mem_addr_t b_idx;
  mem_addr_t r_idx;

  assign PSLVERR = 1'b0;

  ntm_apb_slave apb_slave_inst (
    .CLK     (CLK),
    .RST     (RST),
    .PSEL    (PSEL),
    .PENABLE (PENABLE),
    .PWRITE  (PWRITE),
    .PADDR   (PADDR),
    .PWDATA  (PWDATA),
    .PRDATA  (PRDATA),
    .PREADY  (PREADY),
    .start   (start),
    .op      (op),
    .modulus (modulus),
    .a_idx   (a_idx),
    .b_idx   (b_idx),
    .r_idx   (r_idx),
    .busy    (busy),
    .done    (done),
    .mem     (apb_mem.requester)
  );

  ntm_adder_sequencer sequencer_inst (
    .CLK     (CLK),
    .RST     (RST),
    .start   (start),
    .op      (op),
    .modulus (modulus),
    .a_idx   (a_idx),
    .b_idx   (b_idx),
    .r_idx   (r_idx),
    .busy    (busy),
    .done    (done),
    .mem     (seq_mem.requester)
  );

  ntm_arbitrated_memory memory_inst (
    .CLK     (CLK),
    .RST     (RST),
    .apb_mem (apb_mem.memory),
    .seq_mem (seq_mem.memory)
  );

endmodule

/* dv/ntm_scalar_properties.sv */
// Arbiter checks for the operand memory
// Mutual exclusion of grants, grants only to an asking requester,
// and a bounded wait for the loser of a contested request
module ntm_scalar_properties (
  input logic CLK,
  input logic RST,
  input logic req_apb,
  input logic req_seq,
  input logic gnt_apb,
  input logic gnt_seq
);
  timeunit 1ns;
  timeprecision 1ps;

  // Running count of failed assertions
  int prop_errs;

  // Never two grants at once
  grant_exclusive: assert property (@(posedge CLK) disable iff (RST) !(gnt_apb && gnt_seq))
    else begin
      $error("Both memory requesters granted in the same cycle");
      prop_errs++;
    end

  // Grant implies request
  grant_apb_asked: assert property (@(posedge CLK) disable iff (RST) gnt_apb |-> req_apb)
    else begin
      $error("APB port granted without a request");
      prop_errs++;
    end
  grant_seq_asked: assert property (@(posedge CLK) disable iff (RST) gnt_seq |-> req_seq)
    else begin
      $error("Sequencer port granted without a request");
      prop_errs++;
    end

  // Loser holds its request and wins the next cycle
  apb_wait_bound: assert property (@(posedge CLK) disable iff (RST)
    (req_apb && !gnt_apb) |=> gnt_apb)
    else begin
      $error("APB request not granted within two cycles of a contest");
      prop_errs++;
    end
  seq_wait_bound: assert property (@(posedge CLK) disable iff (RST)
    (req_seq && !gnt_seq) |=> gnt_seq)
    else begin
      $error("Sequencer request not granted within two cycles of a contest");
      prop_errs++;
    end

endmodule

/* dv/ntm_scalar_tb.sv */
// Testbench for the scalar arithmetic peripheral
// Drives APB register and memory window traffic, runs modular add and
// subtract jobs and checks results against a reference model
module ntm_scalar_tb
  import ntm_scalar_pkg::*;
();
  timeunit 1ns;
  timeprecision 1ps;

  localparam int          CLK_PERIOD    = 100;
  localparam int          RESET_CYCLES  = 5;
  localparam int          READY_TIMEOUT = 20;
  localparam int          DONE_TIMEOUT  = 100;
  localparam int          DRAIN_TIMEOUT = 4;
  localparam int unsigned SEED          = 32'hb2ac6d44;

  logic      CLK;
  logic      RST;
  logic      PSEL;
  logic      PENABLE;
  logic      PWRITE;
  apb_addr_t PADDR;
  data_t     PWDATA;
  data_t     PRDATA;
  logic      PREADY;
  logic      PSLVERR;

  // Expected and actual values filled by the stimulus
  string name_q [$];
  data_t exp_q [$];
  data_t act_q [$];
  // Owned by the compare process
  int    chk_idx;
  int    cmp_errs;
  // Owned by the stimulus
  int    flow_errs;
  int    test_base;
  int    tests_run;
  int    tests_failed;
  data_t mem_model [MEM_DEPTH];

  ntm_scalar_top ntm_scalar_top_inst (
    .CLK     (CLK),
    .RST     (RST),
    .PSEL    (PSEL),
    .PENABLE (PENABLE),
    .PWRITE  (PWRITE),
    .PADDR   (PADDR),
    .PWDATA  (PWDATA),
    .PRDATA  (PRDATA),
    .PREADY  (PREADY),
    .PSLVERR (PSLVERR)
  );

  bind ntm_arbitrated_memory ntm_scalar_properties props_inst (
    .CLK     (CLK),
    .RST     (RST),
    .req_apb (req_apb),
    .req_seq (req_seq),
    .gnt_apb (gnt_apb),
    .gnt_seq (gnt_seq)
  );

  always #(CLK_PERIOD / 2) CLK = ~CLK;

  //////////////////////////////
  // Reference model
  function automatic data_t ntm_ref(input data_t a, input data_t b, input ntm_op_t op,
                                    input data_t modulus);
    longint m;
    longint d;
    if (modulus == '0) begin
      // Plain 32-bit wrap
      return (op == OP_ADD) ? a + b : a - b;
    end
    m = longint'({32'h0, modulus});
    if (op == OP_ADD) begin
      d = longint'({32'h0, a}) + longint'({32'h0, b});
    end else begin
      d = longint'({32'h0, a}) - longint'({32'h0, b});
    end
    d = d % m;
    // Remainder keeps the dividend sign
    if (d < 0) begin
      d = d + m;
    end
    return data_t'(d);
  endfunction

  //////////////////////////////
  // Compare process
  always @(negedge CLK) begin
    while (chk_idx < exp_q.size()) begin
      assert (act_q[chk_idx] === exp_q[chk_idx]) else begin
        $display("Error %s: expected %h, actual %h",
                 name_q[chk_idx], exp_q[chk_idx], act_q[chk_idx]);
        cmp_errs++;
      end
      chk_idx++;
    end
  end

  // Errors so far across compare, flow and arbiter checks
  function automatic int error_total();
    return cmp_errs + flow_errs + ntm_scalar_top_inst.memory_inst.props_inst.prop_errs;
  endfunction

  function automatic apb_addr_t win_addr(input mem_addr_t idx);
    return MEM_WINDOW_BASE | {2'b00, idx, 2'b00};
  endfunction

  task automatic expect_value(input string name, input data_t expected, input data_t actual);
    name_q.push_back(name);
    exp_q.push_back(expected);
    act_q.push_back(actual);
  endtask

  // Setup phase then access phase until PREADY
  task automatic bus_transfer(input logic write, input apb_addr_t addr, input data_t wdata,
                              output data_t rdata);
    int   cycles;
    logic ready_seen;
    logic slverr;
    cycles     = 0;
    ready_seen = 1'b0;
    slverr     = 1'b0;
    rdata      = '0;
    @(negedge CLK);
    PSEL    = 1'b1;
    PENABLE = 1'b0;
    PWRITE  = write;
    PADDR   = addr;
    PWDATA  = wdata;
    @(negedge CLK);
    PENABLE = 1'b1;
    while (!ready_seen && cycles < READY_TIMEOUT) begin
      // Settled point ahead of the rising edge
      #(CLK_PERIOD / 4);
      if (PREADY) begin
        ready_seen = 1'b1;
        rdata      = PRDATA;
        slverr     = PSLVERR;
      end
      @(negedge CLK);
      cycles++;
    end
    PSEL    = 1'b0;
    PENABLE = 1'b0;
    if (!ready_seen) begin
      $display("Timeout: PREADY never rose for the access to address %h", addr);
      flow_errs++;
    end else begin
      // No error responses from this slave
      expect_value("pslverr low", '0, data_t'(slverr));
    end
  endtask

  task automatic write_word(input apb_addr_t addr, input data_t data);
    data_t unused_rd;
    bus_transfer(1'b1, addr, data, unused_rd);
  endtask

  task automatic read_word(input apb_addr_t addr, output data_t data);
    bus_transfer(1'b0, addr, '0, data);
  endtask

  //////////////////////////////
  // Job helpers
  task automatic start_job(input ntm_op_t op, input data_t modulus, input data_t a,
                           input data_t b, input mem_addr_t ai, input mem_addr_t bi,
                           input mem_addr_t ri);
    write_word(win_addr(ai), a);
    mem_model[ai] = a;
    write_word(win_addr(bi), b);
    mem_model[bi] = b;
    write_word(REG_MODULUS, modulus);
    write_word(REG_OPADDR, {20'h0, ri, bi, ai});
    // OP plus START
    write_word(REG_CTRL, {30'h0, op, 1'b1});
  endtask

  task automatic wait_done();
    data_t st;
    int    polls;
    st    = '0;
    polls = 0;
    while (!st[STATUS_DONE_BIT] && polls < DONE_TIMEOUT) begin
      read_word(REG_STATUS, st);
      polls++;
    end
    if (!st[STATUS_DONE_BIT]) begin
      $display("Timeout: DONE still low after %0d status reads", polls);
      flow_errs++;
    end
  endtask

  task automatic check_job(input string name, input ntm_op_t op, input data_t modulus,
                           input data_t a, input data_t b, input mem_addr_t ri);
    data_t rd;
    data_t expected;
    expected = ntm_ref(a, b, op, modulus);
    read_word(win_addr(ri), rd);
    expect_value(name, expected, rd);
    if (modulus != '0) begin
      expect_value({name, " below modulus"}, 32'h1, data_t'(rd < modulus));
    end
    mem_model[ri] = expected;
  endtask

  task automatic close_test(input string name);
    int waits;
    int errs;
    waits = 0;
    while (chk_idx < exp_q.size() && waits < DRAIN_TIMEOUT) begin
      @(negedge CLK);
      waits++;
    end
    if (chk_idx < exp_q.size()) begin
      $display("Compare process fell behind in test %s", name);
      flow_errs++;
    end
    errs      = error_total() - test_base;
    test_base = error_total();
    tests_run++;
    if (errs == 0) begin
      $display("Test %s: passed", name);
    end else begin
      tests_failed++;
      $display("Test %s: failed with %0d errors", name, errs);
    end
  endtask

  //////////////////////////////
  // Stimulus
  initial begin : main_flow
    data_t mod;
    data_t a;
    data_t b;
    data_t tmp;
    data_t rd;
    data_t wdata;
    CLK     = 1'b0;
    RST     = 1'b1;
    PSEL    = 1'b0;
    PENABLE = 1'b0;
    PWRITE  = 1'b0;
    PADDR   = '0;
    PWDATA  = '0;
    void'($urandom(SEED));
    repeat (RESET_CYCLES) @(posedge CLK);
    @(negedge CLK);
    RST = 1'b0;

    // Register readback
    read_word(REG_STATUS, rd);
    expect_value("status after reset", '0, rd);
    wdata = $urandom;
    write_word(REG_MODULUS, wdata);
    read_word(REG_MODULUS, rd);
    expect_value("modulus readback", wdata, rd);
    wdata = $urandom & 32'h0000_0FFF;
    write_word(REG_OPADDR, wdata);
    read_word(REG_OPADDR, rd);
    expect_value("opaddr readback", wdata, rd);
    // OP only with START left clear
    write_word(REG_CTRL, 32'h2);
    read_word(REG_CTRL, rd);
    expect_value("ctrl op readback", 32'h2, rd);
    close_test("register_readback");

    // Memory window
    for (int i = 0; i < MEM_DEPTH; i++) begin
      wdata = $urandom;
      write_word(win_addr(mem_addr_t'(i)), wdata);
      mem_model[i] = wdata;
    end
    for (int i = 0; i < MEM_DEPTH; i++) begin
      read_word(win_addr(mem_addr_t'(i)), rd);
      expect_value("window readback", mem_model[i], rd);
    end
    close_test("memory_window");

    // Modular add with operands below a random modulus
    for (int n = 0; n < 4; n++) begin
      mod = $urandom | 32'h2;
      a   = $urandom % mod;
      b   = $urandom % mod;
      start_job(OP_ADD, mod, a, b, mem_addr_t'(n), mem_addr_t'(n + 4), mem_addr_t'(n + 8));
      wait_done();
      check_job("modular add", OP_ADD, mod, a, b, mem_addr_t'(n + 8));
    end
    close_test("modular_add");

    // Modular subtract in both operand orders
    for (int n = 0; n < 4; n++) begin
      mod = $urandom | 32'h2;
      a   = $urandom % (mod - 1);
      b   = a + 1 + ($urandom % (mod - 1 - a));
      start_job(OP_SUB, mod, a, b, 4'd1, 4'd6, 4'd12);
      wait_done();
      check_job("sub a below b", OP_SUB, mod, a, b, 4'd12);
      start_job(OP_SUB, mod, b, a, 4'd3, 4'd7, 4'd13);
      wait_done();
      check_job("sub a at least b", OP_SUB, mod, b, a, 4'd13);
    end
    close_test("modular_subtract");

    // Zero modulus with carry out forced on the add
    a = $urandom | 32'h8000_0000;
    b = $urandom | 32'h8000_0000;
    start_job(OP_ADD, '0, a, b, 4'd0, 4'd1, 4'd14);
    wait_done();
    check_job("wrap add", OP_ADD, '0, a, b, 4'd14);
    a = $urandom;
    b = $urandom;
    if (a > b) begin
      tmp = a;
      a   = b;
      b   = tmp;
    end
    start_job(OP_SUB, '0, a, b, 4'd2, 4'd3, 4'd15);
    wait_done();
    check_job("wrap sub", OP_SUB, '0, a, b, 4'd15);
    close_test("zero_modulus");

    // Window traffic while the sequencer runs
    mod = $urandom | 32'h2;
    a   = $urandom % mod;
    b   = $urandom % mod;
    start_job(OP_ADD, mod, a, b, 4'd0, 4'd1, 4'd2);
    read_word(REG_STATUS, rd);
    // BUSY set and DONE cleared by START
    expect_value("busy after start", 32'h1, rd);
    for (int i = 8; i < 12; i++) begin
      read_word(win_addr(mem_addr_t'(i)), rd);
      expect_value("read during job", mem_model[i], rd);
      wdata = $urandom;
      write_word(win_addr(mem_addr_t'(i + 4)), wdata);
      mem_model[i + 4] = wdata;
    end
    wait_done();
    check_job("contended add", OP_ADD, mod, a, b, 4'd2);
    for (int i = 8; i < MEM_DEPTH; i++) begin
      read_word(win_addr(mem_addr_t'(i)), rd);
      expect_value("window after job", mem_model[i], rd);
    end
    close_test("contention");

    $display("Summary: %0d tests, %0d failed, %0d errors",
             tests_run, tests_failed, error_total());
    if (error_total() == 0) begin
      $display("=== PASS ===");
    end else begin
      $display("=== FAIL ===");
    end
    $finish;
  end

endmodule

/* sim.f */
design/ntm_scalar_pkg.sv
design/ntm_mem_if.sv
design/ntm_scalar_modular_adder.sv
design/ntm_adder_sequencer.sv
design/ntm_arbitrated_memory.sv
design/ntm_apb_slave.sv
design/ntm_scalar_top.sv
dv/ntm_scalar_properties.sv
dv/ntm_scalar_tb.sv

/* run.sh */
#!/bin/sh
# Build and run the scalar peripheral testbench with Verilator.
# The run fails when the log holds the fail message or lacks the pass message.
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --timing --assert --top-module ntm_scalar_tb -f sim.f -o ntm_scalar_sim \
  && ./obj_dir/ntm_scalar_sim > sim.log 2>&1 \
  || echo "Build or simulation ended abnormally"
cat sim.log 2>/dev/null
grep -q "=== FAIL ===" sim.log && exit 1
grep -q "=== PASS ===" sim.log || exit 1
exit 0
